/* filelist.f */
verilog/riscv_pkg.sv
verilog/fetch_unit.sv
verilog/instruction_decoder.sv
verilog/register_file.sv
verilog/forward_unit.sv
verilog/execute_unit.sv
verilog/riscv_core.sv
testbench/riscv_core_checker.sv
testbench/riscv_core_tb.sv

/* testbench/riscv_core_tb.sv */
`timescale 1ns/1ps

module riscv_core_tb;
    import riscv_pkg::*;

    localparam int STORE_TIMEOUT   = 50;
    localparam int TRAILING_CYCLES = 10;

    // One ROM word, plus the expected store for SW rows
    typedef struct {
        word_t instruction;
        logic  is_store;
        word_t address;
        word_t data;
        string name;
    } table_row_t;

    logic  CLK;
    logic  reset;
    word_t instr_addr;
    word_t instr_data;
    logic  data_write;
    word_t data_addr;
    word_t data_wdata;

    table_row_t  stimulus[$];
    word_t       model_regs [32];
    logic [11:0] store_offset;
    integer      seed;
    word_t       random_a;
    word_t       random_b;
    int          row_errors;
    int          tests_passed;
    int          tests_failed;
    int          store_number;

    riscv_core dut0
    (
        .CLK(CLK), .reset(reset),
        .instr_addr(instr_addr), .instr_data(instr_data),
        .data_write(data_write), .data_addr(data_addr), .data_wdata(data_wdata)
    );

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // ------------------------------------------------------------
    // Instruction ROM
    // ------------------------------------------------------------
    function automatic word_t rom_word(input word_t address);
        int index;
        index = int'(address[31:2]);
        // Past the table the core runs on NOPs
        if (index < stimulus.size())
            return stimulus[index].instruction;
        else
            return NOP_INSTRUCTION;
    endfunction

    // Fetch address moves at the edge, so the word for the coming address goes out here
    always @(posedge CLK)
    begin
        if (reset)
            instr_data <= rom_word(RESET_ADDRESS);
        else
            instr_data <= rom_word(instr_addr + PC_STEP);
    end

    // ------------------------------------------------------------
    // Reference model of the ISA subset
    // ------------------------------------------------------------
    function automatic word_t sign_extend_12(input logic [11:0] value);
        return {{20{value[11]}}, value};
    endfunction

    function automatic word_t alu_model(input funct3_t funct3, input logic alternate,
                                        input word_t a, input word_t b);
        word_t result;
        case (funct3)
            FUNCT3_ADD_SUB: result = alternate ? a - b : a + b;
            FUNCT3_SLL:     result = a << b[4:0];
            FUNCT3_SLT:     result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FUNCT3_SLTU:    result = (a < b) ? 32'd1 : 32'd0;
            FUNCT3_XOR:     result = a ^ b;
            FUNCT3_SRL_SRA:
                // Only the shift amount's low five bits count
                if (alternate)
                    result = $signed(a) >>> b[4:0];
                else
                    result = a >> b[4:0];
            FUNCT3_OR:      result = a | b;
            default:        result = a & b;
        endcase
        return result;
    endfunction

    task automatic append_row(input word_t instruction, input logic is_store,
                              input word_t address, input word_t data, input string name);
        table_row_t row;
        row.instruction = instruction;
        row.is_store    = is_store;
        row.address     = address;
        row.data        = data;
        row.name        = name;
        stimulus.push_back(row);
    endtask

    // x0 stays zero whatever is written
    task automatic write_model(input reg_index_t rd, input word_t value);
        if (rd != 5'd0)
            model_regs[rd] = value;
    endtask

    task automatic register_op(input funct3_t funct3, input funct7_t funct7,
                               input reg_index_t rd, input reg_index_t rs1,
                               input reg_index_t rs2);
        word_t value;
        value = alu_model(funct3, funct7 == FUNCT7_ALT, model_regs[rs1], model_regs[rs2]);
        append_row({funct7, rs2, rs1, funct3, rd, OPCODE_OP}, 1'b0, '0, '0, "");
        write_model(rd, value);
    endtask

    task automatic immediate_op(input funct3_t funct3, input logic [11:0] imm,
                                input reg_index_t rd, input reg_index_t rs1);
        word_t value;
        logic  alternate;
        // Bit 30 picks srai, addi has no subtract form
        alternate = (funct3 == FUNCT3_SRL_SRA) && imm[10];
        value = alu_model(funct3, alternate, model_regs[rs1], sign_extend_12(imm));
        append_row({imm, rs1, funct3, rd, OPCODE_OP_IMM}, 1'b0, '0, '0, "");
        write_model(rd, value);
    endtask

    task automatic upper_immediate(input opcode_t opcode, input reg_index_t rd,
                                   input logic [19:0] upper);
        word_t value;
        value = {upper, 12'b0};
        // AUIPC adds the address of its own row
        if (opcode == OPCODE_AUIPC)
            value = value + RESET_ADDRESS + PC_STEP * word_t'(stimulus.size());
        append_row({upper, rd, opcode}, 1'b0, '0, '0, "");
        write_model(rd, value);
    endtask

    // lui then addi, upper part rounded for the sign of the low twelve bits
    task automatic load_constant(input reg_index_t rd, input word_t value);
        word_t upper;
        upper = value + 32'h0000_0800;
        upper_immediate(OPCODE_LUI, rd, upper[31:12]);
        immediate_op(FUNCT3_ADD_SUB, value[11:0], rd, rd);
    endtask

    task automatic store_word(input reg_index_t rs2, input reg_index_t rs1,
                              input logic [11:0] offset, input string name);
        word_t address;
        address = model_regs[rs1] + sign_extend_12(offset);
        append_row({offset[11:5], rs2, rs1, FUNCT3_SW, offset[4:0], OPCODE_STORE},
                   1'b1, address, model_regs[rs2], name);
    endtask

    // Results go to consecutive words off x0
    task automatic store_result(input reg_index_t rs2, input string name);
        store_word(rs2, 5'd0, store_offset, name);
        store_offset = store_offset + 12'd4;
    endtask

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------
    task automatic build_table();
        seed         = 32'h9635d331;
        store_offset = 12'h100;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;

        // Immediate ALU, x1 negative and x2 positive
        immediate_op(FUNCT3_ADD_SUB, 12'hFA3, 5'd1, 5'd0);
        immediate_op(FUNCT3_ADD_SUB, 12'h5C3, 5'd2, 5'd0);
        immediate_op(FUNCT3_ADD_SUB, 12'h064, 5'd3, 5'd1);
        store_result(5'd3, "addi");
        immediate_op(FUNCT3_XOR, 12'h3CC, 5'd3, 5'd1);
        store_result(5'd3, "xori");
        immediate_op(FUNCT3_OR, 12'h7F0, 5'd3, 5'd2);
        store_result(5'd3, "ori");
        immediate_op(FUNCT3_AND, 12'h0F0, 5'd3, 5'd2);
        store_result(5'd3, "andi");
        immediate_op(FUNCT3_SLL, 12'h005, 5'd3, 5'd1);
        store_result(5'd3, "slli");
        immediate_op(FUNCT3_SRL_SRA, 12'h007, 5'd3, 5'd1);
        store_result(5'd3, "srli");
        immediate_op(FUNCT3_SRL_SRA, 12'h407, 5'd3, 5'd1);
        store_result(5'd3, "srai");
        immediate_op(FUNCT3_SLT, 12'hFFB, 5'd3, 5'd1);
        store_result(5'd3, "slti");
        immediate_op(FUNCT3_SLTU, 12'h600, 5'd3, 5'd2);
        store_result(5'd3, "sltiu");

        // Register ALU on random operands
        random_a = $random(seed);
        random_b = $random(seed);
        load_constant(5'd11, random_a);
        load_constant(5'd12, random_b);
        register_op(FUNCT3_ADD_SUB, 7'h00, 5'd13, 5'd11, 5'd12);
        store_result(5'd13, "add");
        register_op(FUNCT3_ADD_SUB, FUNCT7_ALT, 5'd13, 5'd11, 5'd12);
        store_result(5'd13, "sub");
        register_op(FUNCT3_SLL, 7'h00, 5'd13, 5'd11, 5'd12);
        store_result(5'd13, "sll");
        register_op(FUNCT3_SLT, 7'h00, 5'd13, 5'd11, 5'd12);
        store_result(5'd13, "slt");
        register_op(FUNCT3_SLTU, 7'h00, 5'd13, 5'd11, 5'd12);
        store_result(5'd13, "sltu");
        register_op(FUNCT3_XOR, 7'h00, 5'd13, 5'd11, 5'd12);
        store_result(5'd13, "xor");
        register_op(FUNCT3_SRL_SRA, 7'h00, 5'd13, 5'd11, 5'd12);
        store_result(5'd13, "srl");
        register_op(FUNCT3_SRL_SRA, FUNCT7_ALT, 5'd13, 5'd11, 5'd12);
        store_result(5'd13, "sra");
        register_op(FUNCT3_OR, 7'h00, 5'd13, 5'd11, 5'd12);
        store_result(5'd13, "or");
        register_op(FUNCT3_AND, 7'h00, 5'd13, 5'd11, 5'd12);
        store_result(5'd13, "and");

        // Upper immediates
        upper_immediate(OPCODE_LUI, 5'd14, 20'hABCDE);
        store_result(5'd14, "lui");
        upper_immediate(OPCODE_AUIPC, 5'd15, 20'h12345);
        store_result(5'd15, "auipc");

        // Chain reading producers one, two and three rows back
        immediate_op(FUNCT3_ADD_SUB, 12'h007, 5'd5, 5'd0);
        immediate_op(FUNCT3_ADD_SUB, 12'h003, 5'd6, 5'd5);
        register_op(FUNCT3_ADD_SUB, 7'h00, 5'd7, 5'd5, 5'd6);
        register_op(FUNCT3_ADD_SUB, 7'h00, 5'd8, 5'd5, 5'd7);
        register_op(FUNCT3_ADD_SUB, FUNCT7_ALT, 5'd9, 5'd8, 5'd6);
        store_result(5'd9, "chain sub");
        store_result(5'd7, "chain add 1");
        store_result(5'd8, "chain add 2");

        // x0 as destination and as source
        immediate_op(FUNCT3_ADD_SUB, 12'h005, 5'd0, 5'd1);
        store_result(5'd0, "x0 after write");
        register_op(FUNCT3_ADD_SUB, 7'h00, 5'd16, 5'd0, 5'd1);
        store_result(5'd16, "add with x0");

        // Nonzero store offsets off a base register
        load_constant(5'd10, 32'h0000_0400);
        store_word(5'd2, 5'd10, 12'hFF8, "sw offset -8");
        store_word(5'd1, 5'd10, 12'h024, "sw offset +36");
    endtask

    // ------------------------------------------------------------
    // Compare tasks and per-test report
    // ------------------------------------------------------------
    task automatic check_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected)
        begin
            row_errors++;
            $display("[ERROR] %0t ns: %s expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    task automatic check_strobe(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            row_errors++;
            $display("[ERROR] %0t ns: %s expected %b, got %b", $time, what, expected, actual);
        end
    endtask

    task automatic report_test(input string label);
        if (row_errors == 0)
        begin
            tests_passed++;
            $display("%s: ok", label);
        end
        else
        begin
            tests_failed++;
            $display("%s: mismatch", label);
        end
    endtask

    // Outputs sampled on the falling edge, between driving edges
    task automatic check_store(input table_row_t row);
        int    waited;
        string label;
        waited     = 0;
        row_errors = 0;
        store_number++;
        label = $sformatf("store %0d (%s)", store_number, row.name);
        while ((data_write !== 1'b1) && (waited < STORE_TIMEOUT))
        begin
            @(negedge CLK);
            waited++;
        end
        if (data_write !== 1'b1)
        begin
            tests_failed++;
            $display("%s: no store appeared on the data port within %0d cycles",
                     label, STORE_TIMEOUT);
        end
        else
        begin
            check_word(data_addr, row.address, "data_addr");
            check_word(data_wdata, row.data, "data_wdata");
            report_test(label);
            // Step past this store's cycle
            @(negedge CLK);
        end
    endtask

    // Only NOPs follow the table
    task automatic check_quiet_port();
        row_errors = 0;
        repeat (TRAILING_CYCLES)
        begin
            check_strobe(data_write, 1'b0, "data_write after the last store");
            @(negedge CLK);
        end
        report_test("no extra store");
    endtask

    // Fetch and store port properties of the bound checker
    task automatic report_assertions();
        row_errors = 0;
        if (dut0.checker0.assertion_failures != 0)
        begin
            row_errors++;
            $display("bound checker assertions failed %0d times",
                     dut0.checker0.assertion_failures);
        end
        report_test("checker assertions");
    endtask

    initial
    begin
        reset        = 1'b1;
        instr_data   = NOP_INSTRUCTION;
        row_errors   = 0;
        tests_passed = 0;
        tests_failed = 0;
        store_number = 0;
        build_table();
        repeat (4) @(posedge CLK);
        reset <= 1'b0;
        @(negedge CLK);
        foreach (stimulus[i])
        begin
            if (stimulus[i].is_store)
                check_store(stimulus[i]);
        end
        check_quiet_port();
        report_assertions();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* testbench/riscv_core_checker.sv */
`timescale 1ns/1ps

module riscv_core_checker
(
    input logic             CLK,
    input logic             reset,
    input riscv_pkg::word_t instr_addr,
    input logic             data_write,
    input riscv_pkg::word_t data_addr
);
    import riscv_pkg::*;

    // Number of assertion failures so far
    int assertion_failures = 0;

    // Fetch address moves one instruction per cycle, no stalls or jumps
    pc_step: assert property (@(posedge CLK) disable iff (reset)
        !$past(reset) |-> (instr_addr == $past(instr_addr) + PC_STEP))
    else
    begin
        assertion_failures++;
        $error("instr_addr did not advance by one instruction");
    end

    // Store strobe quiet in reset and the first cycle out of it
    quiet_after_reset: assert property (@(posedge CLK)
        $past(reset) |-> !data_write)
    else
    begin
        assertion_failures++;
        $error("data_write high during or right after reset");
    end

    // Word stores only
    aligned_store: assert property (@(posedge CLK)
        data_write |-> (data_addr[1:0] == 2'b00))
    else
    begin
        assertion_failures++;
        $error("data_addr not word aligned on a store");
    end

endmodule

bind riscv_core riscv_core_checker checker0
(
    .CLK(CLK),
    .reset(reset),
    .instr_addr(instr_addr),
    .data_write(data_write),
    .data_addr(data_addr)
);

/* verilog/riscv_core.sv */
`timescale 1ns/1ps

module riscv_core
(
    input  logic             CLK,
    input  logic             reset,
    output riscv_pkg::word_t instr_addr,
    input  riscv_pkg::word_t instr_data,
    output logic             data_write,
    output riscv_pkg::word_t data_addr,
    output riscv_pkg::word_t data_wdata
);
    import riscv_pkg::*;

    // ------------------------------------------------------------
    // Decode stage
    // ------------------------------------------------------------
    word_t      instruction_decode;
    word_t      pc_decode;
    opcode_t    opcode_decode;
    funct3_t    funct3_decode;
    funct7_t    funct7_decode;
    reg_index_t read_index_1_decode;
    reg_index_t read_index_2_decode;
    reg_index_t write_index_decode;
    logic       read_enable_1_decode;
    logic       read_enable_2_decode;
    logic       write_enable_decode;
    word_t      immediate_decode;
    word_t      register_data_1;
    word_t      register_data_2;
    word_t      forward_data_1;
    word_t      forward_data_2;

    // Execute stage
    word_t      pc_execute;
    opcode_t    opcode_execute;
    funct3_t    funct3_execute;
    funct7_t    funct7_execute;
    word_t      immediate_execute;
    word_t      operand_1_execute;
    word_t      operand_2_execute;
    reg_index_t write_index_execute;
    logic       write_enable_execute;
    logic       store_execute;
    word_t      result_execute;
    word_t      store_address_execute;

    // Memory and writeback stages
    word_t      result_memory;
    word_t      store_address_memory;
    word_t      store_data_memory;
    reg_index_t write_index_memory;
    logic       write_enable_memory;
    logic       store_memory;
    word_t      result_writeback;
    reg_index_t write_index_writeback;
    logic       write_enable_writeback;

    fetch_unit fetch0
    (
        .CLK(CLK), .reset(reset),
        .instr_data(instr_data), .instr_addr(instr_addr),
        .decode_instruction(instruction_decode), .decode_pc(pc_decode)
    );

    instruction_decoder decoder0
    (
        .instruction(instruction_decode),
        .opcode(opcode_decode), .funct3(funct3_decode), .funct7(funct7_decode),
        .read_index_1(read_index_1_decode), .read_index_2(read_index_2_decode),
        .write_index(write_index_decode),
        .read_enable_1(read_enable_1_decode), .read_enable_2(read_enable_2_decode),
        .write_enable(write_enable_decode), .immediate(immediate_decode)
    );

    // Written from writeback, read in decode
    register_file register_file0
    (
        .CLK(CLK), .reset(reset),
        .read_index_1(read_index_1_decode), .read_index_2(read_index_2_decode),
        .read_data_1(register_data_1), .read_data_2(register_data_2),
        .write_enable(write_enable_writeback), .write_index(write_index_writeback),
        .write_data(result_writeback)
    );

    forward_unit forward_source_1
    (
        .source_index(read_index_1_decode), .register_data(register_data_1),
        .execute_index(write_index_execute), .execute_enable(write_enable_execute),
        .execute_data(result_execute),
        .memory_index(write_index_memory), .memory_enable(write_enable_memory),
        .memory_data(result_memory),
        .writeback_index(write_index_writeback), .writeback_enable(write_enable_writeback),
        .writeback_data(result_writeback), .operand(forward_data_1)
    );

    forward_unit forward_source_2
    (
        .source_index(read_index_2_decode), .register_data(register_data_2),
        .execute_index(write_index_execute), .execute_enable(write_enable_execute),
        .execute_data(result_execute),
        .memory_index(write_index_memory), .memory_enable(write_enable_memory),
        .memory_data(result_memory),
        .writeback_index(write_index_writeback), .writeback_enable(write_enable_writeback),
        .writeback_data(result_writeback), .operand(forward_data_2)
    );

    // ------------------------------------------------------------
    // Pipeline registers, control bits reset, payload free running
    // ------------------------------------------------------------
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            write_enable_execute   <= 1'b0;
            store_execute          <= 1'b0;
            write_enable_memory    <= 1'b0;
            store_memory           <= 1'b0;
            write_enable_writeback <= 1'b0;
        end
        else
        begin
            write_enable_execute   <= write_enable_decode;
            store_execute          <= (opcode_decode == OPCODE_STORE);
            write_enable_memory    <= write_enable_execute;
            store_memory           <= store_execute;
            write_enable_writeback <= write_enable_memory;
        end
    end

    always_ff @(posedge CLK)
    begin
        pc_execute            <= pc_decode;
        opcode_execute        <= opcode_decode;
        funct3_execute        <= funct3_decode;
        funct7_execute        <= funct7_decode;
        immediate_execute     <= immediate_decode;
        // Sources the instruction does not read enter as zero
        operand_1_execute     <= read_enable_1_decode ? forward_data_1 : '0;
        operand_2_execute     <= read_enable_2_decode ? forward_data_2 : '0;
        write_index_execute   <= write_index_decode;
        result_memory         <= result_execute;
        store_address_memory  <= store_address_execute;
        store_data_memory     <= operand_2_execute;
        write_index_memory    <= write_index_execute;
        result_writeback      <= result_memory;
        write_index_writeback <= write_index_memory;
    end

    execute_unit execute0
    (
        .opcode(opcode_execute), .funct3(funct3_execute), .funct7(funct7_execute),
        .pc(pc_execute), .operand_1(operand_1_execute), .operand_2(operand_2_execute),
        .immediate(immediate_execute),
        .result(result_execute), .store_address(store_address_execute)
    );

    // Data port driven straight from the memory stage
    assign data_write = store_memory;
    assign data_addr  = store_address_memory;
    assign data_wdata = store_data_memory;

endmodule

/* verilog/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit
(
    input  riscv_pkg::opcode_t opcode,
    input  riscv_pkg::funct3_t funct3,
    input  riscv_pkg::funct7_t funct7,
    input  riscv_pkg::word_t   pc,
    input  riscv_pkg::word_t   operand_1,
    input  riscv_pkg::word_t   operand_2,
    input  riscv_pkg::word_t   immediate,
    output riscv_pkg::word_t   result,
    output riscv_pkg::word_t   store_address
);
    import riscv_pkg::*;

    word_t      operand_b;
    logic       alternate;
    logic [4:0] shift_amount;
    word_t      alu_result;

    // Register form uses rs2, immediate form the immediate
    assign operand_b    = (opcode == OPCODE_OP) ? operand_2 : immediate;
    assign shift_amount = operand_b[4:0];
    assign alternate    = (funct7 == FUNCT7_ALT);

    always_comb
    begin
        case (funct3)
            FUNCT3_ADD_SUB:
                // addi has no sub form
                if ((opcode == OPCODE_OP) && alternate)
                    alu_result = operand_1 - operand_b;
                else
                    alu_result = operand_1 + operand_b;
            FUNCT3_SLL:
                alu_result = operand_1 << shift_amount;
            FUNCT3_SLT:
                alu_result = {31'b0, $signed(operand_1) < $signed(operand_b)};
            FUNCT3_SLTU:
                alu_result = {31'b0, operand_1 < operand_b};
            FUNCT3_XOR:
                alu_result = operand_1 ^ operand_b;
            FUNCT3_SRL_SRA:
                // Arithmetic shift keeps the sign
                if (alternate)
                    alu_result = $signed(operand_1) >>> shift_amount;
                else
                    alu_result = operand_1 >> shift_amount;
            FUNCT3_OR:
                alu_result = operand_1 | operand_b;
            FUNCT3_AND:
                alu_result = operand_1 & operand_b;
            default:
                alu_result = '0;
        endcase
    end

    // Upper immediates bypass the ALU
    always_comb
    begin
        case (opcode)
            OPCODE_LUI:   result = immediate;
            OPCODE_AUIPC: result = pc + immediate;
            default:      result = alu_result;
        endcase
    end

    // Base plus S immediate
    assign store_address = operand_1 + immediate;

endmodule

/* verilog/forward_unit.sv */
`timescale 1ns/1ps

module forward_unit
(
    input  riscv_pkg::reg_index_t source_index,
    input  riscv_pkg::word_t      register_data,
    input  riscv_pkg::reg_index_t execute_index,
    input  logic                  execute_enable,
    input  riscv_pkg::word_t      execute_data,
    input  riscv_pkg::reg_index_t memory_index,
    input  logic                  memory_enable,
    input  riscv_pkg::word_t      memory_data,
    input  riscv_pkg::reg_index_t writeback_index,
    input  logic                  writeback_enable,
    input  riscv_pkg::word_t      writeback_data,
    output riscv_pkg::word_t      operand
);
    logic source_valid;

    // x0 always comes from the register file as zero
    assign source_valid = (source_index != '0);

    // Youngest producer wins, execute is the most recent
    always_comb
    begin
        if (source_valid && execute_enable && (execute_index == source_index))
            operand = execute_data;
        else if (source_valid && memory_enable && (memory_index == source_index))
            operand = memory_data;
        else if (source_valid && writeback_enable && (writeback_index == source_index))
            // Written at the coming edge, not yet visible in the file
            operand = writeback_data;
        else
            operand = register_data;
    end

endmodule

/* verilog/register_file.sv */
`timescale 1ns/1ps

module register_file
(
    input  logic                  CLK,
    input  logic                  reset,
    input  riscv_pkg::reg_index_t read_index_1,
    input  riscv_pkg::reg_index_t read_index_2,
    output riscv_pkg::word_t      read_data_1,
    output riscv_pkg::word_t      read_data_2,
    input  logic                  write_enable,
    input  riscv_pkg::reg_index_t write_index,
    input  riscv_pkg::word_t      write_data
);
    import riscv_pkg::*;

    // Architectural registers, entry 0 is never written
    word_t registers [32];

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
            begin
                registers[i] <= '0;
            end
        end
        else if (write_enable && (write_index != '0))
        begin
            registers[write_index] <= write_data;
        end
    end

    // Combinational reads, x0 hardwired to zero
    assign read_data_1 = (read_index_1 == '0) ? '0 : registers[read_index_1];
    assign read_data_2 = (read_index_2 == '0) ? '0 : registers[read_index_2];

endmodule

/* verilog/instruction_decoder.sv */
`timescale 1ns/1ps

module instruction_decoder
(
    input  riscv_pkg::word_t      instruction,
    output riscv_pkg::opcode_t    opcode,
    output riscv_pkg::funct3_t    funct3,
    output riscv_pkg::funct7_t    funct7,
    output riscv_pkg::reg_index_t read_index_1,
    output riscv_pkg::reg_index_t read_index_2,
    output riscv_pkg::reg_index_t write_index,
    output logic                  read_enable_1,
    output logic                  read_enable_2,
    output logic                  write_enable,
    output riscv_pkg::word_t      immediate
);
    import riscv_pkg::*;

    word_t immediate_i;
    word_t immediate_s;
    word_t immediate_u;
    logic  writes_register;

    // Register fields sit at fixed positions in every format
    assign read_index_1 = instruction[19:15];
    assign read_index_2 = instruction[24:20];
    assign write_index  = instruction[11:7];

    // Sign extended I and S immediates, U fills the upper 20 bits
    assign immediate_i = {{20{instruction[31]}}, instruction[31:20]};
    assign immediate_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immediate_u = {instruction[31:12], 12'b0};

    always_comb
    begin
        // Defaults describe addi x0, x0, 0
        opcode          = OPCODE_OP_IMM;
        funct3          = FUNCT3_ADD_SUB;
        funct7          = '0;
        read_enable_1   = 1'b0;
        read_enable_2   = 1'b0;
        writes_register = 1'b0;
        immediate       = '0;
        case (instruction[6:0])
            OPCODE_OP:
            begin
                opcode          = OPCODE_OP;
                funct3          = instruction[14:12];
                funct7          = instruction[31:25];
                read_enable_1   = 1'b1;
                read_enable_2   = 1'b1;
                writes_register = 1'b1;
            end
            OPCODE_OP_IMM:
            begin
                // funct7 is only meaningful for the shifts
                funct3          = instruction[14:12];
                funct7          = instruction[31:25];
                read_enable_1   = 1'b1;
                writes_register = 1'b1;
                immediate       = immediate_i;
            end
            OPCODE_LUI, OPCODE_AUIPC:
            begin
                opcode          = instruction[6:0];
                writes_register = 1'b1;
                immediate       = immediate_u;
            end
            OPCODE_STORE:
            begin
                // Narrow stores fall through as NOP
                if (instruction[14:12] == FUNCT3_SW)
                begin
                    opcode        = OPCODE_STORE;
                    funct3        = FUNCT3_SW;
                    read_enable_1 = 1'b1;
                    read_enable_2 = 1'b1;
                    immediate     = immediate_s;
                end
            end
            default:
            begin
                // Unknown opcode keeps the NOP defaults
            end
        endcase
    end

    // x0 is never a real destination
    assign write_enable = writes_register && (write_index != '0);

endmodule

/* verilog/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
(
    input  logic               CLK,
    input  logic               reset,
    input  riscv_pkg::word_t   instr_data,
    output riscv_pkg::word_t   instr_addr,
    output riscv_pkg::word_t   decode_instruction,
    output riscv_pkg::word_t   decode_pc
);
    import riscv_pkg::*;

    // Program counter of the fetch stage
    word_t pc;

    // Memory answers in the same cycle
    assign instr_addr = pc;

    // No stalls or jumps, so the counter always steps
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            pc                 <= RESET_ADDRESS;
            decode_instruction <= NOP_INSTRUCTION;
            decode_pc          <= RESET_ADDRESS;
        end
        else
        begin
            pc                 <= pc + PC_STEP;
            // Word and its own address move into decode together
            decode_instruction <= instr_data;
            decode_pc          <= pc;
        end
    end

endmodule

/* verilog/riscv_pkg.sv */
// ------------------------------------------------------------
// Shared definitions for the RV32I integer pipeline
// ------------------------------------------------------------
package riscv_pkg;

    // Data, address and instruction word
    typedef logic [31:0] word_t;

    // Register number, 32 architectural registers
    typedef logic [4:0] reg_index_t;

    // Major opcode, bits 6..0 of the instruction
    typedef logic [6:0] opcode_t;

    // Minor operation code, bits 14..12
    typedef logic [2:0] funct3_t;

    // Operation modifier, bits 31..25
    typedef logic [6:0] funct7_t;

    // ------------------------------------------------------------
    // Major opcodes of the supported subset
    // ------------------------------------------------------------
    localparam opcode_t OPCODE_OP     = 7'b011_0011;
    localparam opcode_t OPCODE_OP_IMM = 7'b001_0011;
    localparam opcode_t OPCODE_LUI    = 7'b011_0111;
    localparam opcode_t OPCODE_AUIPC  = 7'b001_0111;
    localparam opcode_t OPCODE_STORE  = 7'b010_0011;

    // ------------------------------------------------------------
    // ALU and store funct3 codes
    // ------------------------------------------------------------
    localparam funct3_t FUNCT3_ADD_SUB = 3'b000;
    localparam funct3_t FUNCT3_SLL     = 3'b001;
    localparam funct3_t FUNCT3_SLT     = 3'b010;
    localparam funct3_t FUNCT3_SLTU    = 3'b011;
    localparam funct3_t FUNCT3_XOR     = 3'b100;
    localparam funct3_t FUNCT3_SRL_SRA = 3'b101;
    localparam funct3_t FUNCT3_OR      = 3'b110;
    localparam funct3_t FUNCT3_AND     = 3'b111;

    // Word store, the only store width kept
    localparam funct3_t FUNCT3_SW = 3'b010;

    // Selects sub over add and sra over srl
    localparam funct7_t FUNCT7_ALT = 7'b010_0000;

    // ------------------------------------------------------------
    // Fixed words
    // ------------------------------------------------------------
    // addi x0, x0, 0
    localparam word_t NOP_INSTRUCTION = 32'h0000_0013;

    // First fetch address after reset
    localparam word_t RESET_ADDRESS = 32'h0000_0000;

    // One instruction per fetch
    localparam word_t PC_STEP = 32'h0000_0004;

endpackage
